// File: verilog/commit_cfg_pkg.sv
// Sizes of the commit stage
// All widths are fixed at compile time and shared by every RTL file
// PC values count 32-bit words, so a PC of PC_W bits covers a 32-bit byte space
// CW must stay equal to 2**P_COMMIT_WIDTH; nothing checks this
// Opcode zero is reserved: it marks an entry that needs no long operation

package commit_cfg_pkg;

   // Commit width as log2, so pop counts fit in P_COMMIT_WIDTH+1 bits
   localparam int P_COMMIT_WIDTH = 2;

   // Number of ROB slots presented per cycle
   localparam int CW = 4;

   // Word address width of the program counter
   localparam int PC_W = 30;

   // Operand and result width
   localparam int DW = 32;

   // Physical register file address width
   localparam int PRF_AW = 6;

   // Long-operation opcode width, memory and system ops share one space
   localparam int OPC_W = 4;

endpackage

// File: verilog/commit_types_pkg.sv
// Bundled signals of the commit stage
// Field widths follow the commit configuration package
// Field order inside the structs is part of the testbench vector format,
// so reordering fields changes the stimulus file layout
// Slot 0 of slot_vec_t sits in the low bits

package commit_types_pkg;

   // Prediction carried through the pipeline with each branch
   typedef struct packed {
      logic                              taken;
      logic [commit_cfg_pkg::PC_W-1:0]   tgt;
   } bpu_upd_t;

   // One completed reorder-buffer entry
   typedef struct packed {
      logic                              valid;
      logic [commit_cfg_pkg::PC_W-1:0]   pc;
      logic [commit_cfg_pkg::OPC_W-1:0]  opc;    // Zero when no long op
      logic [commit_cfg_pkg::DW-1:0]     opa;
      logic [commit_cfg_pkg::DW-1:0]     opb;
      logic                              is_bcc;
      logic                              is_brel;
      logic                              is_breg;
      logic                              fls;    // Mispredict or self flush
      logic [commit_cfg_pkg::PC_W-1:0]   fls_tgt;
      logic [commit_cfg_pkg::PRF_AW-1:0] prd;
      logic                              prd_we;
      bpu_upd_t                          upd;
   } commit_slot_t;

   typedef commit_slot_t [commit_cfg_pkg::CW-1:0] slot_vec_t;

   typedef struct packed {
      logic                              valid;
      logic [commit_cfg_pkg::OPC_W-1:0]  opc;
      logic [commit_cfg_pkg::DW-1:0]     opa;
      logic [commit_cfg_pkg::DW-1:0]     opb;
   } lu_req_t;

   typedef struct packed {
      logic                              valid;
      logic [commit_cfg_pkg::DW-1:0]     data;
   } lu_done_t;

   typedef struct packed {
      logic                              we;
      logic [commit_cfg_pkg::PRF_AW-1:0] addr;
      logic [commit_cfg_pkg::DW-1:0]     data;
   } prf_wr_t;

   // Branch predictor training record
   typedef struct packed {
      logic                              valid;
      logic                              is_bcc;
      logic                              is_brel;
      logic                              is_breg;
      logic                              taken;
      logic [commit_cfg_pkg::PC_W-1:0]   pc;
      logic [commit_cfg_pkg::PC_W-1:0]   npc_act;
      bpu_upd_t                          upd;
   } bpu_wb_t;

endpackage

// File: verilog/slot_classify.sv
// Slot decode and in-order retire mask
// Purely combinational, one cycle of logic from the ROB outputs
// A special entry (long op, flush or branch) may only retire from slot 0,
// and a special slot 0 retires alone
// Invalid slots still take part in the mask; only ready_mask drops them

`timescale 1ns/1ps

module slot_classify
(
   input  commit_types_pkg::slot_vec_t   slots,
   output logic [commit_cfg_pkg::CW-1:0] long_req,
   output logic [commit_cfg_pkg::CW-1:0] single_fu,
   output logic [commit_cfg_pkg::CW-1:0] ready_mask
);
   import commit_cfg_pkg::*;

   logic [CW-1:0] slot_valid;
   logic [CW-1:0] is_branch;
   logic [CW-1:0] cmt_mask;

   always_comb
   begin
      for (int j = 0; j < CW; j++)
      begin
         slot_valid[j] = slots[j].valid;
         long_req[j]   = |slots[j].opc;             // Memory or system op
         is_branch[j]  = slots[j].is_bcc | slots[j].is_brel | slots[j].is_breg;
      end
   end

   // Anything that must see the commit stage on its own
   assign single_fu = long_req | is_branch | get_fls(slots);

   always_comb
   begin
      cmt_mask[0] = 1'b1;                           // Head always eligible
      cmt_mask[1] = ~single_fu[0] & ~single_fu[1];
      for (int j = 2; j < CW; j++)
      begin
         cmt_mask[j] = cmt_mask[j-1] & ~single_fu[j];  // Stop at first special
      end
   end

   assign ready_mask = slot_valid & cmt_mask;

   function automatic logic [CW-1:0] get_fls(input commit_types_pkg::slot_vec_t s);
      logic [CW-1:0] v;
      for (int j = 0; j < CW; j++)
      begin
         v[j] = s[j].fls;
      end
      return v;
   endfunction

endmodule

// File: verilog/commit_ctrl.sv
// Commit control: long-operation handshake, fire vector and writeback
// The long unit gets a one-cycle request and answers with a one-cycle done
// pulse at least one cycle later; a done without a pending request is ignored
// The ROB must hold slot 0 stable while the request is pending
// Only slot 0 can own a long operation, so writeback always targets slot 0's prd

`timescale 1ns/1ps

module commit_ctrl
(
   input  logic                                    clk,
   input  logic                                    rst,
   input  commit_types_pkg::slot_vec_t             slots,
   input  logic [commit_cfg_pkg::CW-1:0]           long_req,
   input  logic [commit_cfg_pkg::CW-1:0]           single_fu,
   input  logic [commit_cfg_pkg::CW-1:0]           ready_mask,
   input  logic                                    flush,
   input  commit_types_pkg::lu_done_t              lu_done,
   output logic [commit_cfg_pkg::CW-1:0]           fire,
   output logic [commit_cfg_pkg::P_COMMIT_WIDTH:0] pop_size,
   output commit_types_pkg::lu_req_t               lu_req,
   output commit_types_pkg::prf_wr_t               prf_wr
);
   import commit_cfg_pkg::*;

   logic lu_pending;       // FSM state, low is idle
   logic lu_pending_nxt;
   logic long_op;
   logic cmt_ce;

   assign long_op = ready_mask[0] & long_req[0];   // Head needs the long unit

   // Hold the whole group until the long unit answers
   assign cmt_ce = ~long_op | lu_done.valid;

   assign fire = ready_mask & {CW{cmt_ce & ~flush}};

   always_comb
   begin
      lu_pending_nxt = lu_pending;
      case (lu_pending)
         1'b0:
            if (long_op)
               lu_pending_nxt = 1'b1;
         1'b1:
            if (lu_done.valid)
               lu_pending_nxt = 1'b0;
         default:
            lu_pending_nxt = 1'b0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         lu_pending <= 1'b0;
      else
         lu_pending <= lu_pending_nxt;
   end

   // Request goes out once, on the idle to pending edge
   always_comb
   begin
      lu_req.valid = ~lu_pending & long_op;
      lu_req.opc   = slots[0].opc;
      lu_req.opa   = slots[0].opa;    // Address or system operand
      lu_req.opb   = slots[0].opb;    // Store data
   end

   always_comb
   begin
      pop_size = '0;
      for (int i = 0; i < CW; i++)
      begin
         pop_size = pop_size + {{P_COMMIT_WIDTH{1'b0}}, fire[i]};
      end
   end

   // fire[0] already carries the flush kill
   always_comb
   begin
      prf_wr.we   = lu_pending & lu_done.valid & fire[0] & slots[0].prd_we;
      prf_wr.addr = slots[0].prd;
      prf_wr.data = lu_done.data;
   end

   // Request leaves idle and is never repeated while pending
   a_req_from_idle : assert property (@(posedge clk) disable iff (rst)
      lu_req.valid |=> !lu_req.valid);

   // Nothing pops or writes back during the self flush
   a_no_fire_in_flush : assert property (@(posedge clk) disable iff (rst)
      flush |-> (pop_size == '0 && !prf_wr.we));

   // Special entries never retire behind another slot
   a_special_at_head : assert property (@(posedge clk) disable iff (rst)
      (fire[CW-1:1] & single_fu[CW-1:1]) == '0);

endmodule

// File: verilog/branch_resolve.sv
// Self flush and branch predictor update for slot 0
// The flush is registered, so the redirect leaves one cycle after slot 0 fires
// Only slot 0 can carry fls or a branch, so the later slots are not looked at
// With fls clear the target register holds pc+1, which is never used as
// a redirect here but keeps the next sequential PC at hand

`timescale 1ns/1ps

module branch_resolve
(
   input  logic                            clk,
   input  logic                            rst,
   input  commit_types_pkg::commit_slot_t  slot0,
   input  logic                            fire0,
   output logic                            flush,
   output logic [commit_cfg_pkg::PC_W-1:0] flush_tgt,
   output commit_types_pkg::bpu_wb_t       bpu_wb
);
   import commit_cfg_pkg::*;

   logic            se_fls_nxt;
   logic [PC_W-1:0] se_tgt_nxt;
   logic [PC_W-1:0] npc_0;
   logic            se_fls_q;
   logic [PC_W-1:0] se_tgt_q;
   logic            is_branch;

   assign npc_0 = slot0.pc + 1'b1;                 // Word addressed PC

   // Drop the request while a flush is out so the pulse stays one cycle
   assign se_fls_nxt = slot0.fls & ~se_fls_q;
   assign se_tgt_nxt = slot0.fls ? slot0.fls_tgt : npc_0;

   always_ff @(posedge clk)
   begin
      if (rst)
         se_fls_q <= 1'b0;
      else if (fire0 | se_fls_q)
         se_fls_q <= se_fls_nxt;
   end

   always_ff @(posedge clk)
   begin
      if (fire0)
         se_tgt_q <= se_tgt_nxt;
   end

   assign flush     = se_fls_q;
   assign flush_tgt = se_tgt_q;

   assign is_branch = slot0.is_bcc | slot0.is_brel | slot0.is_breg;

   // A set fls on a branch means the prediction was wrong
   always_comb
   begin
      bpu_wb.valid   = fire0 & is_branch;
      bpu_wb.is_bcc  = slot0.is_bcc;
      bpu_wb.is_brel = slot0.is_brel;
      bpu_wb.is_breg = slot0.is_breg;
      bpu_wb.taken   = slot0.upd.taken ^ slot0.fls;
      bpu_wb.pc      = slot0.pc;
      bpu_wb.npc_act = slot0.fls ? slot0.fls_tgt : slot0.upd.tgt;
      bpu_wb.upd     = slot0.upd;
   end

   // The flushed group cannot fire, so no back-to-back flush
   a_flush_one_cycle : assert property (@(posedge clk) disable iff (rst)
      flush |=> !flush);

endmodule

// File: verilog/commit_top.sv
// Commit stage top level
// Takes up to CW completed ROB entries per cycle and retires them in order
// fire and pop_size are combinational from slots; the ROB pops on them
// in the same cycle and keeps every entry that did not fire
// The long unit is external and must follow the request/done pulse protocol
// flush redirects the front end one cycle after a flushing slot 0 retires

`timescale 1ns/1ps

module commit_top
(
   input  logic                                    clk,
   input  logic                                    rst,
   input  commit_types_pkg::slot_vec_t             slots,
   input  commit_types_pkg::lu_done_t              lu_done,
   output logic [commit_cfg_pkg::CW-1:0]           fire,
   output logic [commit_cfg_pkg::P_COMMIT_WIDTH:0] pop_size,
   output commit_types_pkg::lu_req_t               lu_req,
   output commit_types_pkg::prf_wr_t               prf_wr,
   output logic                                    flush,
   output logic [commit_cfg_pkg::PC_W-1:0]         flush_tgt,
   output commit_types_pkg::bpu_wb_t               bpu_wb
);
   import commit_cfg_pkg::*;

   logic [CW-1:0] long_req;
   logic [CW-1:0] single_fu;
   logic [CW-1:0] ready_mask;

   slot_classify u_classify (
      .slots      (slots),
      .long_req   (long_req),
      .single_fu  (single_fu),
      .ready_mask (ready_mask)
   );

   commit_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .slots      (slots),
      .long_req   (long_req),
      .single_fu  (single_fu),
      .ready_mask (ready_mask),
      .flush      (flush),
      .lu_done    (lu_done),
      .fire       (fire),
      .pop_size   (pop_size),
      .lu_req     (lu_req),
      .prf_wr     (prf_wr)
   );

   branch_resolve u_branch (
      .clk        (clk),
      .rst        (rst),
      .slot0      (slots[0]),
      .fire0      (fire[0]),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .bpu_wb     (bpu_wb)
   );

endmodule

// File: verif/tb_commit.sv
// Testbench for the commit stage
// Vectors come from verif/commit_stim.txt, so the simulator must start in the
// project root. One line is one test; tests run back to back with no idle cycle
// The long unit is modeled here with a random latency of 1 to 6 cycles
// A test right after a flushing test must not hold a long op in slot 0,
// because its request would leave during the flush cycle

`timescale 1ns/1ps

module tb_commit;
   import commit_cfg_pkg::*;
   import commit_types_pkg::*;

   localparam int FIELDS       = 18;
   localparam int NUM_TESTS    = 29;
   localparam int DONE_TIMEOUT = 16;     // Cycles to wait for lu_done
   localparam int RUN_LIMIT    = 10000;

   // Column positions inside one vector line
   localparam int F_FLAGS0 = 0;
   localparam int F_PC     = 1;
   localparam int F_OPA    = 2;
   localparam int F_OPB    = 3;
   localparam int F_FTGT   = 4;
   localparam int F_UTGT   = 5;
   localparam int F_FLAGS1 = 6;          // Slots 1 to 3 follow
   localparam int F_LUD    = 9;
   localparam int E_FIRE   = 10;
   localparam int E_POP    = 11;
   localparam int E_FLUSH  = 12;
   localparam int E_TGT    = 13;
   localparam int E_TAKEN  = 14;
   localparam int E_NPC    = 15;
   localparam int E_ADDR   = 16;
   localparam int E_DATA   = 17;

   logic                    clk;
   logic                    rst;
   slot_vec_t               slots;
   lu_done_t                lu_done;
   logic [CW-1:0]           fire;
   logic [P_COMMIT_WIDTH:0] pop_size;
   lu_req_t                 lu_req;
   prf_wr_t                 prf_wr;
   logic                    flush;
   logic [PC_W-1:0]         flush_tgt;
   bpu_wb_t                 bpu_wb;

   logic [31:0]     stim_mem [NUM_TESTS*FIELDS];
   logic [DW-1:0]   cur_lu_data;                 // Result the long unit returns
   integer          seed;
   int              err_count;
   int              tests_run;
   int              tests_failed;
   bit              timed_out;
   bit              prev_flush;
   logic [PC_W-1:0] prev_tgt;

   commit_top uut (
      .clk       (clk),
      .rst       (rst),
      .slots     (slots),
      .lu_done   (lu_done),
      .fire      (fire),
      .pop_size  (pop_size),
      .lu_req    (lu_req),
      .prf_wr    (prf_wr),
      .flush     (flush),
      .flush_tgt (flush_tgt),
      .bpu_wb    (bpu_wb)
   );

   always #2 clk = ~clk;

   // Flag word: [0] valid [1] bcc [2] brel [3] breg [4] fls [5] prd_we [6] taken
   // [11:8] opc [21:16] prd
   function automatic commit_slot_t make_slot(input logic [31:0] flags,
                                              input logic [31:0] pc,
                                              input logic [31:0] opa,
                                              input logic [31:0] opb,
                                              input logic [31:0] ftgt,
                                              input logic [31:0] utgt);
      commit_slot_t s;
      s.valid     = flags[0];
      s.pc        = pc[PC_W-1:0];
      s.opc       = flags[11:8];
      s.opa       = opa;
      s.opb       = opb;
      s.is_bcc    = flags[1];
      s.is_brel   = flags[2];
      s.is_breg   = flags[3];
      s.fls       = flags[4];
      s.fls_tgt   = ftgt[PC_W-1:0];
      s.prd       = flags[21:16];
      s.prd_we    = flags[5];
      s.upd.taken = flags[6];
      s.upd.tgt   = utgt[PC_W-1:0];
      return s;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond === 1'b1)
      else
      begin
         $display("Error at %0t ns: %s", $time, what);
         err_count++;
      end
   endtask

   task automatic check_quiet_outputs();
      check_val("flush", 32'(flush), 32'd0);
      check_val("lu_req.valid", 32'(lu_req.valid), 32'd0);
      check_val("prf_wr.we", 32'(prf_wr.we), 32'd0);
      check_val("bpu_wb.valid", 32'(bpu_wb.valid), 32'd0);
   endtask

   // The flush cycle that follows a flushing slot 0
   task automatic check_flush_cycle();
      check_val("flush", 32'(flush), 32'd1);
      check_val("flush_tgt", 32'(flush_tgt), 32'(prev_tgt));
      check_val("fire", 32'(fire), 32'd0);
      check_val("prf_wr.we", 32'(prf_wr.we), 32'd0);
      check_val("bpu_wb.valid", 32'(bpu_wb.valid), 32'd0);
   endtask

   task automatic run_test(input int t);
      logic [31:0]  w [FIELDS];
      slot_vec_t    vec;
      commit_slot_t s0;
      logic         exp_long;
      logic         exp_we;
      logic         exp_bpu;
      bit           got_done;
      int           errs_before;
      errs_before = err_count;
      tests_run++;
      for (int k = 0; k < FIELDS; k++)
      begin
         w[k] = stim_mem[t*FIELDS + k];
      end
      s0 = make_slot(w[F_FLAGS0], w[F_PC], w[F_OPA], w[F_OPB], w[F_FTGT], w[F_UTGT]);
      vec[0] = s0;
      for (int j = 1; j < CW; j++)
      begin
         vec[j] = make_slot(w[F_FLAGS1 + j - 1], w[F_PC] + 32'(j), '0, '0, '0, '0);
      end
      exp_long    = s0.valid & (s0.opc != '0);
      cur_lu_data = w[F_LUD];

      @(posedge clk);
      slots <= vec;
      @(negedge clk);
      if (prev_flush)
      begin
         check_flush_cycle();
         @(posedge clk);                           // Same slots stay on
         @(negedge clk);
      end
      check_val("flush", 32'(flush), 32'd0);

      if (lu_req.valid === 1'b1)
      begin
         check_true(exp_long, "long unit request without a long op in slot 0");
         check_val("lu_req.opc", 32'(lu_req.opc), 32'(s0.opc));
         check_val("lu_req.opa", lu_req.opa, s0.opa);
         check_val("lu_req.opb", lu_req.opb, s0.opb);
         check_val("fire", 32'(fire), 32'd0);
         got_done = 1'b0;
         for (int k = 0; k < DONE_TIMEOUT && !got_done; k++)
         begin
            @(posedge clk);
            @(negedge clk);
            if (lu_done.valid === 1'b1)
               got_done = 1'b1;
            else
            begin
               check_val("fire", 32'(fire), 32'd0);       // Group held until done
               check_val("lu_req.valid", 32'(lu_req.valid), 32'd0);
            end
         end
         if (!got_done)
         begin
            $display("Timeout at %0t ns: no done from the long unit in test %0d", $time, t);
            timed_out = 1'b1;
         end
      end
      else
         check_true(!exp_long, "no long unit request for the long op in slot 0");

      if (!timed_out)
      begin
         exp_we  = exp_long & s0.prd_we & w[E_FIRE][0];
         exp_bpu = w[E_FIRE][0] & (s0.is_bcc | s0.is_brel | s0.is_breg);
         check_val("fire", 32'(fire), w[E_FIRE]);
         check_val("pop_size", 32'(pop_size), w[E_POP]);
         check_val("prf_wr.we", 32'(prf_wr.we), 32'(exp_we));
         if (exp_we)
         begin
            check_val("prf_wr.addr", 32'(prf_wr.addr), w[E_ADDR]);
            check_val("prf_wr.data", prf_wr.data, w[E_DATA]);
         end
         check_val("bpu_wb.valid", 32'(bpu_wb.valid), 32'(exp_bpu));
         if (exp_bpu)
         begin
            check_val("bpu_wb.taken", 32'(bpu_wb.taken), w[E_TAKEN]);
            check_val("bpu_wb.npc_act", 32'(bpu_wb.npc_act), w[E_NPC]);
            check_val("bpu_wb.pc", 32'(bpu_wb.pc), 32'(s0.pc));
            check_val("bpu_wb.is_bcc/is_brel/is_breg",
                      32'({bpu_wb.is_bcc, bpu_wb.is_brel, bpu_wb.is_breg}),
                      32'({s0.is_bcc, s0.is_brel, s0.is_breg}));
         end
         prev_flush = w[E_FLUSH][0];
         prev_tgt   = w[E_TGT][PC_W-1:0];
      end

      if (err_count == errs_before && !timed_out)
         $display("test %0d passed", t);
      else
      begin
         tests_failed++;
         $display("test %0d failed with %0d errors", t, err_count - errs_before);
      end
   endtask

   // Empty slots after the last test so a final flush can be seen
   task automatic drain_flush();
      @(posedge clk);
      slots <= '0;
      @(negedge clk);
      if (prev_flush)
         check_flush_cycle();
      @(posedge clk);
      @(negedge clk);
      check_quiet_outputs();
   endtask

   initial
   begin : long_unit_model
      int delay;
      seed    = 32'hb9cb;
      lu_done = '0;
      for (int c = 0; c < RUN_LIMIT; c++)
      begin
         @(negedge clk);
         if (lu_req.valid === 1'b1)
         begin
            delay = 1 + int'($unsigned($random(seed)) % 32'd6);
            repeat (delay) @(posedge clk);
            lu_done.valid <= 1'b1;
            lu_done.data  <= cur_lu_data;
            @(posedge clk);
            lu_done.valid <= 1'b0;                 // One-cycle done pulse
         end
      end
   end

   initial
   begin
      clk          = 1'b0;
      rst          = 1'b1;
      slots        = '0;
      cur_lu_data  = '0;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      prev_flush   = 1'b0;
      prev_tgt     = '0;
      $readmemh("verif/commit_stim.txt", stim_mem);
      check_true(!$isunknown(stim_mem[NUM_TESTS*FIELDS-1]), "stimulus file missing or short");

      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_quiet_outputs();

      for (int t = 0; t < NUM_TESTS && !timed_out; t++)
      begin
         run_test(t);
      end
      if (!timed_out)
         drain_flush();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
      if (timed_out || err_count != 0)
      begin
         $display("Simulation failed");
      end
      else
      begin
         $display("Simulation passed");
      end
      $finish;
   end

endmodule

// File: verif/commit_stim.txt
// f0 pc0 opa opb fls_tgt upd_tgt f1 f2 f3 lu_data | fire pop flush flush_tgt taken npc addr data
// flags: [0] valid [1] bcc [2] brel [3] breg [4] fls [5] prd_we [6] taken [11:8] opc [21:16] prd
// plain slots, valid patterns
1      100 0        0        0        0   1  1   1  0         f 4 0 0        0 0        0  0
1      104 0        0        0        0   0  1   1  0         d 3 0 0        0 0        0  0
0      108 0        0        0        0   1  1   1  0         e 3 0 0        0 0        0  0
0      10c 0        0        0        0   0  0   0  0         0 0 0 0        0 0        0  0
1      110 0        0        0        0   1  0   1  0         b 3 0 0        0 0        0  0
// special slots behind slot 0 block the rest
1      120 0        0        0        0   1  3   1  0         3 2 0 0        0 0        0  0
1      130 0        0        0        0   11 1   1  0         1 1 0 0        0 0        0  0
1      140 0        0        0        0   1  1   5  0         7 3 0 0        0 0        0  0
1      150 0        0        0        0   1  301 1  0         3 2 0 0        0 0        0  0
1      160 0        0        0        0   10 1   1  0         1 1 0 0        0 0        0  0
// branches in slot 0, with and without fls
3      200 0        0        0        300 1  1   1  0         1 1 0 0        0 300      0  0
43     210 0        0        0        280 1  1   1  0         1 1 0 0        1 280      0  0
59     220 0        0        3f0      250 1  1   1  0         1 1 1 3f0      0 3f0      0  0
1      230 0        0        0        0   1  1   1  0         f 4 0 0        0 0        0  0
15     240 0        0        120      400 1  1   0  0         1 1 1 120      1 120      0  0
1      250 0        0        0        0   3  1   1  0         1 1 0 0        0 0        0  0
// self flush, then a flushing branch presented in the flush cycle
11     260 0        0        2a0      0   1  1   1  0         1 1 1 2a0      0 0        0  0
13     270 0        0        500      278 1  1   1  0         1 1 1 500      1 500      0  0
1      280 0        0        0        0   1  1   1  0         f 4 0 0        0 0        0  0
// long operations in slot 0
50221  300 1000     2000     0        0   1  1   1  cafe      1 1 0 0        0 0        5  cafe
c0701  304 11       22       0        0   1  1   1  beef      1 1 0 0        0 0        c  beef
3f0f21 308 deadbeef 12345678 0        0   0  1   1  5a5a5a5a  1 1 0 0        0 0        3f 5a5a5a5a
200    30c 0        0        0        0   1  1   1  0         0 0 0 0        0 0        0  0
10121  310 7        8        0        0   1  0   0  1111      1 1 0 0        0 0        1  1111
43     320 0        0        0        340 1  1   1  0         1 1 0 0        1 340      0  0
// fls on a later slot, then flushes at the end of the run
1      330 0        0        0        0   1  1   11 0         7 3 0 0        0 0        0  0
11     340 0        0        10       0   1  1   1  0         1 1 1 10       0 0        0  0
1      350 0        0        0        0   1  0   0  0         3 2 0 0        0 0        0  0
1b     360 0        0        3fffffff 0   1  1   1  0         1 1 1 3fffffff 1 3fffffff 0  0

// File: src.f
verilog/commit_cfg_pkg.sv
verilog/commit_types_pkg.sv
verilog/slot_classify.sv
verilog/commit_ctrl.sv
verilog/branch_resolve.sv
verilog/commit_top.sv
verif/tb_commit.sv

// File: run.sh
#!/bin/sh
# Builds and runs the commit stage testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_commit -f src.f -o sim_commit \
   && ./obj_dir/sim_commit > sim.log 2>&1 \
   || { echo "Build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || grep -q "Simulation passed" sim.log
